/* source/pixel_macros.svh */
`ifndef PIXEL_MACROS_SVH
`define PIXEL_MACROS_SVH

// command address width.
// bits 11:10 select the channel, 9:5 the row, 4:0 the column.
`define PIXEL_ADDR_W 12

// width of one colour channel.
`define PIXEL_CHAN_W 16

// rows and columns of the local pixel memory.
`define PIXEL_DIM 32

// decode fifo depth, also the upstream's starting credit count.
`define CMD_DEPTH 4

// result fifo depth.
`define RES_DEPTH 4

// credits the downstream grants at reset.
`define RES_CREDITS 2

`endif

/* source/pixel_pkg.sv */
package pixel_pkg;

	////////////////////////////////////////////////////////////////////////////
	// command opcodes
	////////////////////////////////////////////////////////////////////////////

	// nop is dropped in decode and never reaches execute.
	// write and add touch one channel, read and luma return a result.
	typedef enum logic [2:0]
	{
		OP_NOP   = 3'd0,
		OP_WRITE = 3'd1,
		OP_ADD   = 3'd2,
		OP_READ  = 3'd3,
		OP_LUMA  = 3'd4
	} pixel_op_e;

	////////////////////////////////////////////////////////////////////////////
	// channel select, taken from the top two address bits
	////////////////////////////////////////////////////////////////////////////

	// chan_none is a legal code; a write or add to it is ignored.
	typedef enum logic [1:0]
	{
		CHAN_RED   = 2'd0,
		CHAN_GREEN = 2'd1,
		CHAN_BLUE  = 2'd2,
		CHAN_NONE  = 2'd3
	} chan_e;

endpackage

/* source/local_mem_pixel.sv */
`timescale 1ns/1ns
`include "pixel_macros.svh"

module local_mem_pixel import pixel_pkg::*;
(
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          read_pixel_signal,
	input  logic [`PIXEL_ADDR_W-1:0]      read_pixel_addr,
	input  logic                          write_pixel_signal,
	input  logic [`PIXEL_ADDR_W-1:0]      write_pixel_addr,
	input  logic [`PIXEL_CHAN_W-1:0]      write_pixel_data,
	output logic [3*`PIXEL_CHAN_W-1:0]    read_pixel_data
);
	localparam int COORD_W = $clog2(`PIXEL_DIM);

	// [0] red, [1] green, [2] blue.
	// packed so a whole pixel reads out as blue, green, red.
	logic [2:0][`PIXEL_CHAN_W-1:0] pixel_mem [`PIXEL_DIM][`PIXEL_DIM];

	chan_e              wr_chan;
	logic [COORD_W-1:0] wr_row;
	logic [COORD_W-1:0] wr_col;
	logic [COORD_W-1:0] rd_row;
	logic [COORD_W-1:0] rd_col;

	assign wr_chan = chan_e'(write_pixel_addr[`PIXEL_ADDR_W-1:2*COORD_W]);
	assign wr_row  = write_pixel_addr[2*COORD_W-1:COORD_W];
	assign wr_col  = write_pixel_addr[COORD_W-1:0];
	// the channel bits of the read address select nothing.
	// a read always returns all three channels.
	assign rd_row  = read_pixel_addr[2*COORD_W-1:COORD_W];
	assign rd_col  = read_pixel_addr[COORD_W-1:0];

	////////////////////////////////////////////////////////////////////////////
	// write port
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			// whole array comes up black.
			for (int i = 0; i < `PIXEL_DIM; i++)
			begin
				for (int j = 0; j < `PIXEL_DIM; j++)
				begin
					pixel_mem[i][j] <= '0;
				end
			end
		end
		else if (write_pixel_signal && (wr_chan != CHAN_NONE))
		begin
			// only the addressed channel changes, the other two hold.
			pixel_mem[wr_row][wr_col][wr_chan] <= write_pixel_data;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// read port
	////////////////////////////////////////////////////////////////////////////

	// combinational, shows the pixel as of the last clock edge.
	always_comb
	begin
		if (read_pixel_signal)
			read_pixel_data = pixel_mem[rd_row][rd_col];
		else
			read_pixel_data = '0;
	end

endmodule

/* source/pixel_cmd_decode.sv */
`timescale 1ns/1ns
`include "pixel_macros.svh"

module pixel_cmd_decode import pixel_pkg::*;
(
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            cmd_valid,
	input  pixel_op_e                       cmd_op,
	input  logic [`PIXEL_ADDR_W-1:0]        cmd_addr,
	input  logic [`PIXEL_CHAN_W-1:0]        cmd_data,
	input  logic                            issue_ready,
	output logic                            cmd_credit,
	output logic                            issue_valid,
	output pixel_op_e                       issue_op,
	output chan_e                           issue_chan,
	output logic [$clog2(`PIXEL_DIM)-1:0]   issue_row,
	output logic [$clog2(`PIXEL_DIM)-1:0]   issue_col,
	output logic [`PIXEL_CHAN_W-1:0]        issue_data
);
	localparam int PTR_W   = $clog2(`CMD_DEPTH);
	localparam int CNT_W   = $clog2(`CMD_DEPTH + 1);
	localparam int COORD_W = $clog2(`PIXEL_DIM);

	// raw command storage.
	pixel_op_e                op_mem   [`CMD_DEPTH];
	logic [`PIXEL_ADDR_W-1:0] addr_mem [`CMD_DEPTH];
	logic [`PIXEL_CHAN_W-1:0] data_mem [`CMD_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] fill_cnt;
	logic             fifo_empty;
	logic             fifo_full;
	logic             pop;
	logic [`PIXEL_ADDR_W-1:0] head_addr;

	assign fifo_empty = (fill_cnt == '0);
	assign fifo_full  = (fill_cnt == CNT_W'(`CMD_DEPTH));

	////////////////////////////////////////////////////////////////////////////
	// head split
	////////////////////////////////////////////////////////////////////////////

	assign head_addr  = addr_mem[rd_ptr];
	assign issue_op   = op_mem[rd_ptr];
	assign issue_data = data_mem[rd_ptr];
	assign issue_chan = chan_e'(head_addr[`PIXEL_ADDR_W-1:2*COORD_W]);
	assign issue_row  = head_addr[2*COORD_W-1:COORD_W];
	assign issue_col  = head_addr[COORD_W-1:0];

	// nop entries are never offered to execute.
	assign issue_valid = !fifo_empty && (issue_op != OP_NOP);
	// a nop leaves on its own, anything else waits for the handshake.
	assign pop = !fifo_empty && ((issue_op == OP_NOP) || issue_ready);

	// payload lands in the slot at the write pointer.
	always_ff @(posedge clk)
	begin
		if (cmd_valid)
		begin
			op_mem[wr_ptr]   <= cmd_op;
			addr_mem[wr_ptr] <= cmd_addr;
			data_mem[wr_ptr] <= cmd_data;
		end
	end

	// pointers, fill level and the credit pulse.
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			fill_cnt   <= '0;
			cmd_credit <= 1'b0;
		end
		else
		begin
			if (cmd_valid)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			fill_cnt   <= fill_cnt + CNT_W'(cmd_valid) - CNT_W'(pop);
			// one credit back, one cycle after the entry leaves.
			cmd_credit <= pop;
		end
	end

	// the upstream spent a credit it did not hold.
	a_no_push_full: assert property (@(posedge clk) disable iff (rst)
		cmd_valid |-> !fifo_full);

	// no credit can leak out while reset is held.
	a_credit_rst: assert property (@(posedge clk) rst |-> !cmd_credit);

endmodule

/* source/pixel_execute.sv */
`timescale 1ns/1ns
`include "pixel_macros.svh"

module pixel_execute import pixel_pkg::*;
(
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          issue_valid,
	input  pixel_op_e                     issue_op,
	input  chan_e                         issue_chan,
	input  logic [$clog2(`PIXEL_DIM)-1:0] issue_row,
	input  logic [$clog2(`PIXEL_DIM)-1:0] issue_col,
	input  logic [`PIXEL_CHAN_W-1:0]      issue_data,
	input  logic                          res_room,
	output logic                          issue_ready,
	output logic                          res_push,
	output pixel_op_e                     res_push_op,
	output logic [3*`PIXEL_CHAN_W-1:0]    res_push_data
);
	localparam int CW = `PIXEL_CHAN_W;

	logic                     read_pixel_signal;
	logic [`PIXEL_ADDR_W-1:0] read_pixel_addr;
	logic [3*CW-1:0]          read_pixel_data;
	logic                     write_pixel_signal;
	logic [`PIXEL_ADDR_W-1:0] write_pixel_addr;
	logic [CW-1:0]            write_pixel_data;

	logic            fire;
	logic            needs_res;
	logic [CW-1:0]   pix_red;
	logic [CW-1:0]   pix_green;
	logic [CW-1:0]   pix_blue;
	logic [CW-1:0]   chan_val;
	logic [CW:0]     add_sum;
	logic [CW-1:0]   add_sat;
	logic [CW+1:0]   luma_sum;
	logic [CW-1:0]   luma_val;

	////////////////////////////////////////////////////////////////////////////
	// issue handshake
	////////////////////////////////////////////////////////////////////////////

	// only read and luma occupy a result slot.
	assign needs_res   = (issue_op == OP_READ) || (issue_op == OP_LUMA);
	// a result-producing op stalls when the result fifo has no room.
	assign issue_ready = !needs_res || res_room;
	assign fire        = issue_valid && issue_ready;

	// one address serves both ports, the pixel is always the issued one.
	assign read_pixel_signal = issue_valid;
	assign read_pixel_addr   = {issue_chan, issue_row, issue_col};
	assign write_pixel_addr  = read_pixel_addr;

	local_mem_pixel u_mem
	(
		.clk                (clk),
		.rst                (rst),
		.read_pixel_signal  (read_pixel_signal),
		.read_pixel_addr    (read_pixel_addr),
		.write_pixel_signal (write_pixel_signal),
		.write_pixel_addr   (write_pixel_addr),
		.write_pixel_data   (write_pixel_data),
		.read_pixel_data    (read_pixel_data)
	);

	////////////////////////////////////////////////////////////////////////////
	// datapath
	////////////////////////////////////////////////////////////////////////////

	assign pix_red   = read_pixel_data[CW-1:0];
	assign pix_green = read_pixel_data[2*CW-1:CW];
	assign pix_blue  = read_pixel_data[3*CW-1:2*CW];

	// current value of the selected channel.
	always_comb
	begin
		case (issue_chan)
			CHAN_RED:   chan_val = pix_red;
			CHAN_GREEN: chan_val = pix_green;
			CHAN_BLUE:  chan_val = pix_blue;
			default:    chan_val = '0;
		endcase
	end

	// saturating add, clamps at all ones.
	assign add_sum = {1'b0, chan_val} + {1'b0, issue_data};
	assign add_sat = add_sum[CW] ? {CW{1'b1}} : add_sum[CW-1:0];

	// r + 2g + b, then drop two bits.
	assign luma_sum = {2'b00, pix_red} + {1'b0, pix_green, 1'b0} + {2'b00, pix_blue};
	assign luma_val = luma_sum[CW+1:2];

	// memory update happens on the issue edge.
	assign write_pixel_signal = fire && ((issue_op == OP_WRITE) || (issue_op == OP_ADD));
	assign write_pixel_data   = (issue_op == OP_ADD) ? add_sat : issue_data;

	// result goes to the queue on the same edge.
	assign res_push    = fire && needs_res;
	assign res_push_op = issue_op;

	always_comb
	begin
		case (issue_op)
			OP_READ: res_push_data = read_pixel_data;
			OP_LUMA: res_push_data = {{(2*CW){1'b0}}, luma_val};
			default: res_push_data = '0;
		endcase
	end

	// a stalled command stays on the issue port until it moves.
	a_stall_hold: assert property (@(posedge clk) disable iff (rst)
		(issue_valid && !issue_ready) |=> (issue_valid && $stable(issue_op)
			&& $stable(issue_row) && $stable(issue_col)));

endmodule

/* source/pixel_result_queue.sv */
`timescale 1ns/1ns
`include "pixel_macros.svh"

module pixel_result_queue import pixel_pkg::*;
(
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          res_push,
	input  pixel_op_e                     res_push_op,
	input  logic [3*`PIXEL_CHAN_W-1:0]    res_push_data,
	input  logic                          res_credit,
	output logic                          res_room,
	output logic                          res_valid,
	output pixel_op_e                     res_op,
	output logic [3*`PIXEL_CHAN_W-1:0]    res_data
);
	localparam int PTR_W  = $clog2(`RES_DEPTH);
	localparam int CNT_W  = $clog2(`RES_DEPTH + 1);
	// one spare code so an overflow stays visible.
	localparam int CRED_W = $clog2(`RES_CREDITS + 2);

	pixel_op_e                      op_mem   [`RES_DEPTH];
	logic [3*`PIXEL_CHAN_W-1:0]     data_mem [`RES_DEPTH];

	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	logic [CNT_W-1:0]  fill_cnt;
	logic [CRED_W-1:0] credit_cnt;
	logic [CRED_W-1:0] avail_cnt;
	logic              fifo_empty;
	logic              pop;

	assign fifo_empty = (fill_cnt == '0);
	assign res_room   = (fill_cnt != CNT_W'(`RES_DEPTH));

	////////////////////////////////////////////////////////////////////////////
	// credit accounting
	////////////////////////////////////////////////////////////////////////////

	// the beat now on res_valid already owns one credit.
	assign avail_cnt = credit_cnt - CRED_W'(res_valid);
	assign pop       = !fifo_empty && (avail_cnt != '0);

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			credit_cnt <= CRED_W'(`RES_CREDITS);
		else
			credit_cnt <= credit_cnt + CRED_W'(res_credit) - CRED_W'(res_valid);
	end

	// fifo storage.
	always_ff @(posedge clk)
	begin
		if (res_push)
		begin
			op_mem[wr_ptr]   <= res_push_op;
			data_mem[wr_ptr] <= res_push_data;
		end
	end

	// registered output beat.
	always_ff @(posedge clk)
	begin
		if (pop)
		begin
			res_op   <= op_mem[rd_ptr];
			res_data <= data_mem[rd_ptr];
		end
	end

	// pointers, level and the valid flag.
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			fill_cnt  <= '0;
			res_valid <= 1'b0;
		end
		else
		begin
			if (res_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			fill_cnt  <= fill_cnt + CNT_W'(res_push) - CNT_W'(pop);
			res_valid <= pop;
		end
	end

	// downstream returned more than it was ever given.
	a_credit_max: assert property (@(posedge clk) disable iff (rst)
		credit_cnt <= CRED_W'(`RES_CREDITS));

	// every beat sent is backed by a credit.
	a_valid_credit: assert property (@(posedge clk) disable iff (rst)
		res_valid |-> (credit_cnt != '0));

endmodule

/* source/pixel_engine_top.sv */
`timescale 1ns/1ns
`include "pixel_macros.svh"

module pixel_engine_top import pixel_pkg::*;
(
	input  logic                          clk,
	input  logic                          rst,
	// upstream command port.
	input  logic                          cmd_valid,
	input  pixel_op_e                     cmd_op,
	input  logic [`PIXEL_ADDR_W-1:0]      cmd_addr,
	input  logic [`PIXEL_CHAN_W-1:0]      cmd_data,
	output logic                          cmd_credit,
	// downstream result port.
	output logic                          res_valid,
	output pixel_op_e                     res_op,
	output logic [3*`PIXEL_CHAN_W-1:0]    res_data,
	input  logic                          res_credit
);
	localparam int COORD_W = $clog2(`PIXEL_DIM);

	// decode to execute.
	logic                      issue_valid;
	logic                      issue_ready;
	pixel_op_e                 issue_op;
	chan_e                     issue_chan;
	logic [COORD_W-1:0]        issue_row;
	logic [COORD_W-1:0]        issue_col;
	logic [`PIXEL_CHAN_W-1:0]  issue_data;

	// execute to result queue.
	logic                      res_push;
	pixel_op_e                 res_push_op;
	logic [3*`PIXEL_CHAN_W-1:0] res_push_data;
	logic                      res_room;

	////////////////////////////////////////////////////////////////////////////
	// pipeline stages
	////////////////////////////////////////////////////////////////////////////

	pixel_cmd_decode u_decode
	(
		.clk         (clk),
		.rst         (rst),
		.cmd_valid   (cmd_valid),
		.cmd_op      (cmd_op),
		.cmd_addr    (cmd_addr),
		.cmd_data    (cmd_data),
		.issue_ready (issue_ready),
		.cmd_credit  (cmd_credit),
		.issue_valid (issue_valid),
		.issue_op    (issue_op),
		.issue_chan  (issue_chan),
		.issue_row   (issue_row),
		.issue_col   (issue_col),
		.issue_data  (issue_data)
	);

	pixel_execute u_execute
	(
		.clk           (clk),
		.rst           (rst),
		.issue_valid   (issue_valid),
		.issue_op      (issue_op),
		.issue_chan    (issue_chan),
		.issue_row     (issue_row),
		.issue_col     (issue_col),
		.issue_data    (issue_data),
		.res_room      (res_room),
		.issue_ready   (issue_ready),
		.res_push      (res_push),
		.res_push_op   (res_push_op),
		.res_push_data (res_push_data)
	);

	pixel_result_queue u_result
	(
		.clk           (clk),
		.rst           (rst),
		.res_push      (res_push),
		.res_push_op   (res_push_op),
		.res_push_data (res_push_data),
		.res_credit    (res_credit),
		.res_room      (res_room),
		.res_valid     (res_valid),
		.res_op        (res_op),
		.res_data      (res_data)
	);

endmodule

/* dv/pixel_checker.sv */
`timescale 1ns/1ns
`include "pixel_macros.svh"

module pixel_checker import pixel_pkg::*;
(
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          cmd_valid,
	input  logic                          cmd_credit,
	input  logic                          res_valid,
	input  pixel_op_e                     res_op,
	input  logic [3*`PIXEL_CHAN_W-1:0]    res_data,
	input  logic                          res_credit,
	output int                            error_cnt,
	output int                            pass_cnt,
	output int                            pending_cnt
);
	// expected results in table order.
	// the stimulus side only appends, the monitor walks head_idx forward.
	string                      name_q [$];
	pixel_op_e                  op_q   [$];
	logic [3*`PIXEL_CHAN_W-1:0] exp_q  [$];
	int                         push_cnt = 0;
	int                         head_idx = 0;

	// counts seen on the ports.
	int cmd_cnt      = 0;
	int credit_cnt   = 0;
	int beat_cnt     = 0;
	int returned_cnt = 0;

	// compare results and end-of-run checks keep separate tallies.
	int cmp_err    = 0;
	int cmp_pass   = 0;
	int drain_err  = 0;
	int drain_pass = 0;

	assign error_cnt   = cmp_err + drain_err;
	assign pass_cnt    = cmp_pass + drain_pass;
	assign pending_cnt = push_cnt - head_idx;

	////////////////////////////////////////////////////////////////////////////
	// expectation entry
	////////////////////////////////////////////////////////////////////////////

	// queued when the command leaves the testbench.
	task automatic expect_result(input string name, input pixel_op_e op,
		input logic [3*`PIXEL_CHAN_W-1:0] value);
		name_q.push_back(name);
		op_q.push_back(op);
		exp_q.push_back(value);
		push_cnt++;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// port monitor
	////////////////////////////////////////////////////////////////////////////

	// sampled mid-cycle, all dut outputs are settled by then.
	always @(negedge clk)
	begin
		if (!rst)
		begin
			if (cmd_valid)
				cmd_cnt++;
			if (cmd_credit)
				credit_cnt++;
			if (res_valid)
			begin
				beat_cnt++;
				// credits granted strictly before this beat.
				if (beat_cnt > `RES_CREDITS + returned_cnt)
				begin
					$display("error: result beat %0d was sent with no downstream credit left",
						beat_cnt);
					cmp_err++;
				end
				if (head_idx >= push_cnt)
				begin
					$display("error: result %h arrived with no expected result pending",
						res_data);
					cmp_err++;
				end
				else
				begin
					if ((res_op !== op_q[head_idx]) || (res_data !== exp_q[head_idx]))
					begin
						$display("[FAIL] %s expected op %0d data %h actual op %0d data %h",
							name_q[head_idx], op_q[head_idx], exp_q[head_idx],
							res_op, res_data);
						cmp_err++;
					end
					else
					begin
						$display("[PASS] %s got op %0d data %h", name_q[head_idx],
							res_op, res_data);
						cmp_pass++;
					end
					head_idx++;
				end
			end
			// a credit returned now can only back a later beat.
			if (res_credit)
				returned_cnt++;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// drain checks
	////////////////////////////////////////////////////////////////////////////

	// upstream credits must all come home once the engine is idle.
	task automatic finish_checks(input int tb_credits);
		if (credit_cnt != cmd_cnt)
		begin
			$display("[FAIL] credit_drain expected %0d actual %0d", cmd_cnt, credit_cnt);
			drain_err++;
		end
		else if (tb_credits != `CMD_DEPTH)
		begin
			$display("[FAIL] credit_count expected %0d actual %0d", `CMD_DEPTH, tb_credits);
			drain_err++;
		end
		else
		begin
			$display("[PASS] credit_drain got %0d pulses for %0d commands", credit_cnt, cmd_cnt);
			drain_pass++;
		end
		$display("summary: %0d checks ok, %0d failed, %0d results, %0d commands",
			pass_cnt, error_cnt, beat_cnt, cmd_cnt);
	endtask

endmodule

/* dv/tb_pixel_engine.sv */
`timescale 1ns/1ns
`include "pixel_macros.svh"

module tb_pixel_engine import pixel_pkg::*;
();
	localparam int     CLK_PERIOD  = 40;
	localparam int     TBL_LEN     = 22;
	localparam longint WATCHDOG_NS = (TBL_LEN * 12 + 50) * CLK_PERIOD;

	logic                          clk;
	logic                          rst;
	logic                          cmd_valid;
	pixel_op_e                     cmd_op;
	logic [`PIXEL_ADDR_W-1:0]      cmd_addr;
	logic [`PIXEL_CHAN_W-1:0]      cmd_data;
	logic                          cmd_credit;
	logic                          res_valid;
	pixel_op_e                     res_op;
	logic [3*`PIXEL_CHAN_W-1:0]    res_data;
	logic                          res_credit;
	int                            error_cnt;
	int                            pass_cnt;
	int                            pending_cnt;

	// stimulus table.
	string                      tbl_name    [TBL_LEN];
	pixel_op_e                  tbl_op      [TBL_LEN];
	logic [`PIXEL_ADDR_W-1:0]   tbl_addr    [TBL_LEN];
	logic [`PIXEL_CHAN_W-1:0]   tbl_data    [TBL_LEN];
	bit                         tbl_has_res [TBL_LEN];
	logic [3*`PIXEL_CHAN_W-1:0] tbl_exp     [TBL_LEN];
	int                         tbl_fill = 0;

	// upstream credits are the start value minus sent plus returned.
	int up_sent     = 0;
	int up_returned = 0;

	// downstream credit return delays, one per result beat.
	int          delay_q [$];
	int          ret_head   = 0;
	logic [31:0] lfsr_state = 32'h0f462e99;

	pixel_engine_top i_dut
	(
		.clk        (clk),
		.rst        (rst),
		.cmd_valid  (cmd_valid),
		.cmd_op     (cmd_op),
		.cmd_addr   (cmd_addr),
		.cmd_data   (cmd_data),
		.cmd_credit (cmd_credit),
		.res_valid  (res_valid),
		.res_op     (res_op),
		.res_data   (res_data),
		.res_credit (res_credit)
	);

	pixel_checker u_check
	(
		.clk         (clk),
		.rst         (rst),
		.cmd_valid   (cmd_valid),
		.cmd_credit  (cmd_credit),
		.res_valid   (res_valid),
		.res_op      (res_op),
		.res_data    (res_data),
		.res_credit  (res_credit),
		.error_cnt   (error_cnt),
		.pass_cnt    (pass_cnt),
		.pending_cnt (pending_cnt)
	);

	////////////////////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////////////////////

	// channel in 11:10, row in 9:5, column in 4:0.
	function automatic logic [`PIXEL_ADDR_W-1:0] addr_of(input chan_e ch, input logic [4:0] row,
		input logic [4:0] col);
		return {ch, row, col};
	endfunction

	// taps 32, 22, 2, 1; the new bit enters at the bottom.
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic int up_credits();
		return `CMD_DEPTH - up_sent + up_returned;
	endfunction

	task automatic add_entry(input string name, input pixel_op_e op,
		input logic [`PIXEL_ADDR_W-1:0] addr, input logic [`PIXEL_CHAN_W-1:0] data,
		input bit has_res, input logic [3*`PIXEL_CHAN_W-1:0] exp);
		tbl_name[tbl_fill]    = name;
		tbl_op[tbl_fill]      = op;
		tbl_addr[tbl_fill]    = addr;
		tbl_data[tbl_fill]    = data;
		tbl_has_res[tbl_fill] = has_res;
		tbl_exp[tbl_fill]     = exp;
		tbl_fill++;
	endtask

	// results pack blue, green, red from high to low.
	task automatic load_table();
		// untouched memory reads as zero.
		add_entry("rd_blank", OP_READ, addr_of(CHAN_RED, 5'd3, 5'd7), '0, 1'b1, '0);
		add_entry("luma_blank", OP_LUMA, addr_of(CHAN_RED, 5'd31, 5'd31), '0, 1'b1, '0);
		// one write per channel, then the whole pixel.
		add_entry("wr_red", OP_WRITE, addr_of(CHAN_RED, 5'd5, 5'd9), 16'h1234, 1'b0, '0);
		add_entry("wr_green", OP_WRITE, addr_of(CHAN_GREEN, 5'd5, 5'd9), 16'h5678, 1'b0, '0);
		add_entry("wr_blue", OP_WRITE, addr_of(CHAN_BLUE, 5'd5, 5'd9), 16'h9abc, 1'b0, '0);
		add_entry("rd_rgb", OP_READ, addr_of(CHAN_RED, 5'd5, 5'd9), '0, 1'b1,
			48'h9abc_5678_1234);
		// channel 3 is ignored.
		add_entry("wr_chan3", OP_WRITE, addr_of(CHAN_NONE, 5'd5, 5'd9), 16'hffff, 1'b0, '0);
		add_entry("rd_chan3", OP_READ, addr_of(CHAN_RED, 5'd5, 5'd9), '0, 1'b1,
			48'h9abc_5678_1234);
		add_entry("nop_skip", OP_NOP, '0, '0, 1'b0, '0);
		// 65000 + 1000 clamps to 65535, red gets 300, blue stays 0.
		add_entry("wr_green_base", OP_WRITE, addr_of(CHAN_GREEN, 5'd2, 5'd4), 16'd65000,
			1'b0, '0);
		add_entry("add_green_sat", OP_ADD, addr_of(CHAN_GREEN, 5'd2, 5'd4), 16'd1000, 1'b0, '0);
		add_entry("add_red", OP_ADD, addr_of(CHAN_RED, 5'd2, 5'd4), 16'd300, 1'b0, '0);
		add_entry("rd_add", OP_READ, addr_of(CHAN_RED, 5'd2, 5'd4), '0, 1'b1,
			48'h0000_ffff_012c);
		// (65535 + 2*65535 + 2) / 4 = 49151, needs the full 18-bit sum.
		add_entry("wr_l_red", OP_WRITE, addr_of(CHAN_RED, 5'd17, 5'd30), 16'hffff, 1'b0, '0);
		add_entry("wr_l_green", OP_WRITE, addr_of(CHAN_GREEN, 5'd17, 5'd30), 16'hffff, 1'b0, '0);
		add_entry("wr_l_blue", OP_WRITE, addr_of(CHAN_BLUE, 5'd17, 5'd30), 16'h0002, 1'b0, '0);
		add_entry("luma_trunc", OP_LUMA, addr_of(CHAN_RED, 5'd17, 5'd30), '0, 1'b1,
			48'h0000_0000_bfff);
		// blue becomes 0x9abf, luma 88547 / 4 truncates to 22136.
		add_entry("add_blue", OP_ADD, addr_of(CHAN_BLUE, 5'd5, 5'd9), 16'd3, 1'b0, '0);
		add_entry("luma_rgb", OP_LUMA, addr_of(CHAN_RED, 5'd5, 5'd9), '0, 1'b1,
			48'h0000_0000_5678);
		// back to back results stress the downstream credits.
		add_entry("rd_final", OP_READ, addr_of(CHAN_RED, 5'd5, 5'd9), '0, 1'b1,
			48'h9abf_5678_1234);
		add_entry("rd_add_again", OP_READ, addr_of(CHAN_BLUE, 5'd2, 5'd4), '0, 1'b1,
			48'h0000_ffff_012c);
		add_entry("luma_blank_end", OP_LUMA, addr_of(CHAN_RED, 5'd0, 5'd31), '0, 1'b1, '0);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// clock, watchdog and credit bookkeeping
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("timeout: the engine did not finish the command table in time");
		$display("test failed");
		$finish;
	end

	// credits back from decode, and a random hold time for each result beat.
	always @(negedge clk)
	begin
		logic [2:0] dly;
		if (!rst)
		begin
			if (cmd_credit)
				up_returned++;
			if (res_valid)
			begin
				dly = '0;
				for (int b = 0; b < 3; b++)
				begin
					lfsr_state = lfsr_step(lfsr_state);
					dly = {dly[1:0], lfsr_state[0]};
				end
				delay_q.push_back(int'(dly));
			end
		end
	end

	// hands downstream credits back one pulse at a time.
	initial
	begin : credit_return
		int wait_left;
		bit armed;
		res_credit = 1'b0;
		wait_left = 0;
		armed = 1'b0;
		forever
		begin
			@(posedge clk);
			#2;
			res_credit = 1'b0;
			if (!armed && (ret_head < delay_q.size()))
			begin
				wait_left = delay_q[ret_head];
				armed = 1'b1;
			end
			if (armed)
			begin
				if (wait_left == 0)
				begin
					res_credit = 1'b1;
					ret_head++;
					armed = 1'b0;
				end
				else
					wait_left--;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////////////////////

	initial
	begin : stimulus
		int idx;
		rst = 1'b1;
		cmd_valid = 1'b0;
		cmd_op = OP_NOP;
		cmd_addr = '0;
		cmd_data = '0;
		idx = 0;
		load_table();
		repeat (2) @(posedge clk);
		#2;
		rst = 1'b0;
		// one command per cycle while an upstream credit is held.
		while (idx < TBL_LEN)
		begin
			@(posedge clk);
			#2;
			if (up_credits() > 0)
			begin
				cmd_valid = 1'b1;
				cmd_op = tbl_op[idx];
				cmd_addr = tbl_addr[idx];
				cmd_data = tbl_data[idx];
				if (tbl_has_res[idx])
					u_check.expect_result(tbl_name[idx], tbl_op[idx], tbl_exp[idx]);
				up_sent++;
				idx++;
			end
			else
				cmd_valid = 1'b0;
		end
		@(posedge clk);
		#2;
		cmd_valid = 1'b0;
		// last entry returns a result, so every credit pulse is out by then.
		wait (pending_cnt == 0);
		repeat (2) @(posedge clk);
		u_check.finish_checks(up_credits());
		if (error_cnt == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

/* build.f */
+incdir+source
source/pixel_pkg.sv
source/local_mem_pixel.sv
source/pixel_cmd_decode.sv
source/pixel_execute.sv
source/pixel_result_queue.sv
source/pixel_engine_top.sv
dv/pixel_checker.sv
dv/tb_pixel_engine.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module tb_pixel_engine -o sim_pixel_engine

# the printed summary decides the outcome, so a nonzero exit of the sim is not fatal here.
out=$(./obj_dir/sim_pixel_engine 2>&1) || true
echo "$out"
echo "$out" | grep -q "test passed"
